//--- src/adam_cfg_pkg.sv
package adam_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // default widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    parameter int ADDR_WIDTH_DEF  = 32; // host address bus.
    parameter int DATA_WIDTH_DEF  = 32; // host data bus.
    parameter int GPIO_WIDTH_DEF  = 16; // pins in the bank.
    parameter int TIMER_WIDTH_DEF = 32; // counter and compare.

    // alternate function select per pin.
    parameter int FUNC_WIDTH = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // axi response codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01, // never issued, no exclusive access.
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

//--- src/adam_regmap_pkg.sv
package adam_regmap_pkg;

    // register opcodes, one per mapped register.
    typedef enum logic [3:0] {
        NONE       = 4'd0, // unmapped.
        GPIO_OUT   = 4'd1,
        GPIO_MODE  = 4'd2,
        GPIO_OTYPE = 4'd3,
        GPIO_IN    = 4'd4, // read only.
        GPIO_FUNC  = 4'd5,
        TMR_CTRL   = 4'd6,
        TMR_CMP    = 4'd7,
        TMR_COUNT  = 4'd8, // read only.
        TMR_STATUS = 4'd9
    } reg_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte offsets, low address byte only
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    parameter logic [7:0] GPIO_OUT_OFF   = 8'h00;
    parameter logic [7:0] GPIO_MODE_OFF  = 8'h04;
    parameter logic [7:0] GPIO_OTYPE_OFF = 8'h08;
    parameter logic [7:0] GPIO_IN_OFF    = 8'h0C;
    parameter logic [7:0] GPIO_FUNC_OFF  = 8'h10;

    parameter logic [7:0] TMR_CTRL_OFF   = 8'h20; // bit 0 enables counting.
    parameter logic [7:0] TMR_CMP_OFF    = 8'h24;
    parameter logic [7:0] TMR_COUNT_OFF  = 8'h28;
    parameter logic [7:0] TMR_STATUS_OFF = 8'h2C; // bit 0 match, write one to clear.

endpackage

//--- src/adam_bus_ctrl.sv
`timescale 1ns/100ps

module adam_bus_ctrl import adam_cfg_pkg::*, adam_regmap_pkg::*; #(
    parameter ADDR_WIDTH = ADDR_WIDTH_DEF,
    parameter DATA_WIDTH = DATA_WIDTH_DEF
) (
    input  logic clk,
    input  logic arst_n_i,

    input  logic pause_req_i,
    output logic pause_ack_o,

    input  logic [ADDR_WIDTH-1:0]   s_axil_aw_addr_i,
    input  logic [2:0]              s_axil_aw_prot_i,
    input  logic                    s_axil_aw_valid_i,
    output logic                    s_axil_aw_ready_o,
    input  logic [DATA_WIDTH-1:0]   s_axil_w_data_i,
    input  logic [DATA_WIDTH/8-1:0] s_axil_w_strb_i,
    input  logic                    s_axil_w_valid_i,
    output logic                    s_axil_w_ready_o,
    output axi_resp_e               s_axil_b_resp_o,
    output logic                    s_axil_b_valid_o,
    input  logic                    s_axil_b_ready_i,
    input  logic [ADDR_WIDTH-1:0]   s_axil_ar_addr_i,
    input  logic [2:0]              s_axil_ar_prot_i,
    input  logic                    s_axil_ar_valid_i,
    output logic                    s_axil_ar_ready_o,
    output logic [DATA_WIDTH-1:0]   s_axil_r_data_o,
    output axi_resp_e               s_axil_r_resp_o,
    output logic                    s_axil_r_valid_o,
    input  logic                    s_axil_r_ready_i,

    output logic                    reg_wr_o,
    output reg_op_e                 reg_op_o,
    output logic [DATA_WIDTH-1:0]   reg_wdata_o,
    output logic [DATA_WIDTH/8-1:0] reg_wstrb_o,
    output logic                    timer_run_o,
    input  logic [DATA_WIDTH-1:0]   gpio_rdata_i,
    input  logic [DATA_WIDTH-1:0]   tmr_rdata_i
);

    typedef enum logic [2:0] {
        IDLE, WR_ACCEPT, WR_RESP, RD_ACCEPT, RD_RESP, PAUSED
    } state_e;

    state_e                  state_q;
    state_e                  state_d;
    logic [7:0]              addr_q; // only the low byte is decoded.
    logic [DATA_WIDTH-1:0]   wdata_q;
    logic [DATA_WIDTH/8-1:0] wstrb_q;
    logic [DATA_WIDTH-1:0]   rdata_q;
    axi_resp_e               resp_q;
    logic                    wr_start;
    logic                    rd_start;
    logic                    wr_err;
    logic [DATA_WIDTH-1:0]   rdata_mux;

    assign wr_start = s_axil_aw_valid_i && s_axil_w_valid_i;
    assign rd_start = s_axil_ar_valid_i && !wr_start; // writes win ties.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transaction FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pause_req_i) state_d = PAUSED;
                else if (wr_start) state_d = WR_ACCEPT;
                else if (rd_start) state_d = RD_ACCEPT;
            end
            WR_ACCEPT: state_d = WR_RESP;
            WR_RESP:   if (s_axil_b_ready_i) state_d = IDLE;
            RD_ACCEPT: state_d = RD_RESP;
            RD_RESP:   if (s_axil_r_ready_i) state_d = IDLE;
            PAUSED:    if (!pause_req_i) state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && state_d == WR_ACCEPT) begin
            addr_q  <= s_axil_aw_addr_i[7:0];
            wdata_q <= s_axil_w_data_i;
            wstrb_q <= s_axil_w_strb_i;
        end else if (state_q == IDLE && state_d == RD_ACCEPT) begin
            addr_q <= s_axil_ar_addr_i[7:0];
        end
        if (state_q == WR_ACCEPT) begin
            resp_q <= wr_err ? SLVERR : OKAY;
        end
        if (state_q == RD_ACCEPT) begin
            resp_q  <= (reg_op_o == NONE) ? SLVERR : OKAY;
            rdata_q <= rdata_mux;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode and read mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (addr_q)
            GPIO_OUT_OFF:   reg_op_o = GPIO_OUT;
            GPIO_MODE_OFF:  reg_op_o = GPIO_MODE;
            GPIO_OTYPE_OFF: reg_op_o = GPIO_OTYPE;
            GPIO_IN_OFF:    reg_op_o = GPIO_IN;
            GPIO_FUNC_OFF:  reg_op_o = GPIO_FUNC;
            TMR_CTRL_OFF:   reg_op_o = TMR_CTRL;
            TMR_CMP_OFF:    reg_op_o = TMR_CMP;
            TMR_COUNT_OFF:  reg_op_o = TMR_COUNT;
            TMR_STATUS_OFF: reg_op_o = TMR_STATUS;
            default:        reg_op_o = NONE;
        endcase
    end

    assign wr_err = (reg_op_o == NONE) || (reg_op_o == GPIO_IN) || (reg_op_o == TMR_COUNT);

    always_comb begin
        case (reg_op_o)
            GPIO_OUT, GPIO_MODE, GPIO_OTYPE, GPIO_IN, GPIO_FUNC: rdata_mux = gpio_rdata_i;
            TMR_CTRL, TMR_CMP, TMR_COUNT, TMR_STATUS:            rdata_mux = tmr_rdata_i;
            default:                                             rdata_mux = '0;
        endcase
    end

    assign s_axil_aw_ready_o = (state_q == WR_ACCEPT);
    assign s_axil_w_ready_o  = (state_q == WR_ACCEPT);
    assign s_axil_b_valid_o  = (state_q == WR_RESP);
    assign s_axil_b_resp_o   = resp_q;
    assign s_axil_ar_ready_o = (state_q == RD_ACCEPT);
    assign s_axil_r_valid_o  = (state_q == RD_RESP);
    assign s_axil_r_data_o   = rdata_q;
    assign s_axil_r_resp_o   = resp_q;

    assign reg_wr_o    = (state_q == WR_ACCEPT) && !wr_err; // no strobe on SLVERR.
    assign reg_wdata_o = wdata_q;
    assign reg_wstrb_o = wstrb_q;
    assign pause_ack_o = (state_q == PAUSED);
    assign timer_run_o = (state_q != PAUSED);

    a_one_resp: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(s_axil_b_valid_o && s_axil_r_valid_o));

    a_no_wr_paused: assert property (@(posedge clk) disable iff (!arst_n_i)
        pause_ack_o |-> !reg_wr_o);

endmodule

//--- src/adam_gpio.sv
`timescale 1ns/100ps

module adam_gpio import adam_cfg_pkg::*, adam_regmap_pkg::*; #(
    parameter DATA_WIDTH = DATA_WIDTH_DEF,
    parameter GPIO_WIDTH = GPIO_WIDTH_DEF
) (
    input  logic clk,
    input  logic arst_n_i,

    input  logic                    reg_wr_i,
    input  reg_op_e                 reg_op_i,
    input  logic [DATA_WIDTH-1:0]   reg_wdata_i,
    input  logic [DATA_WIDTH/8-1:0] reg_wstrb_i,
    output logic [DATA_WIDTH-1:0]   gpio_rdata_o,

    input  logic [GPIO_WIDTH-1:0]            gpio_i,
    output logic [GPIO_WIDTH-1:0]            gpio_o,
    output logic [GPIO_WIDTH-1:0]            gpio_mode_o,
    output logic [GPIO_WIDTH-1:0]            gpio_otype_o,
    output logic [FUNC_WIDTH*GPIO_WIDTH-1:0] gpio_func_o
);

    localparam FUNC_BITS = FUNC_WIDTH*GPIO_WIDTH;

    logic [DATA_WIDTH-1:0] wmask;
    logic [GPIO_WIDTH-1:0] out_q;
    logic [GPIO_WIDTH-1:0] mode_q;
    logic [GPIO_WIDTH-1:0] otype_q;
    logic [FUNC_BITS-1:0]  func_q;
    logic [GPIO_WIDTH-1:0] in_meta_q;
    logic [GPIO_WIDTH-1:0] in_sync_q;

    if (GPIO_WIDTH > 16) begin : g_width_check
        $error("adam_gpio supports at most 16 pins.");
    end

    // new register value with only the strobed bytes replaced.
    function automatic logic [DATA_WIDTH-1:0] merge(input logic [DATA_WIDTH-1:0] old_v);
        return (old_v & ~wmask) | (reg_wdata_i & wmask);
    endfunction

    for (genvar b = 0; b < DATA_WIDTH/8; b++) begin : g_mask
        assign wmask[b*8 +: 8] = {8{reg_wstrb_i[b]}};
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q   <= '0;
            mode_q  <= '0;
            otype_q <= '0;
            func_q  <= '0;
        end else if (reg_wr_i) begin
            case (reg_op_i)
                GPIO_OUT:   out_q   <= GPIO_WIDTH'(merge(DATA_WIDTH'(out_q)));
                GPIO_MODE:  mode_q  <= GPIO_WIDTH'(merge(DATA_WIDTH'(mode_q)));
                GPIO_OTYPE: otype_q <= GPIO_WIDTH'(merge(DATA_WIDTH'(otype_q)));
                GPIO_FUNC:  func_q  <= FUNC_BITS'(merge(DATA_WIDTH'(func_q)));
                default: ; // timer opcodes.
            endcase
        end
    end

    // two-flop synchronizer for the pad inputs.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_i;
            in_sync_q <= in_meta_q;
        end
    end

    always_comb begin
        case (reg_op_i)
            GPIO_OUT:   gpio_rdata_o = DATA_WIDTH'(out_q);
            GPIO_MODE:  gpio_rdata_o = DATA_WIDTH'(mode_q);
            GPIO_OTYPE: gpio_rdata_o = DATA_WIDTH'(otype_q);
            GPIO_IN:    gpio_rdata_o = DATA_WIDTH'(in_sync_q);
            GPIO_FUNC:  gpio_rdata_o = DATA_WIDTH'(func_q);
            default:    gpio_rdata_o = '0;
        endcase
    end

    assign gpio_o       = out_q;
    assign gpio_mode_o  = mode_q;
    assign gpio_otype_o = otype_q;
    assign gpio_func_o  = func_q;

    a_in_read_only: assert property (@(posedge clk) disable iff (!arst_n_i)
        reg_wr_i |-> reg_op_i != GPIO_IN);

endmodule

//--- src/adam_timer.sv
`timescale 1ns/100ps

module adam_timer import adam_cfg_pkg::*, adam_regmap_pkg::*; #(
    parameter DATA_WIDTH  = DATA_WIDTH_DEF,
    parameter TIMER_WIDTH = TIMER_WIDTH_DEF
) (
    input  logic clk,
    input  logic arst_n_i,

    input  logic                    reg_wr_i,
    input  reg_op_e                 reg_op_i,
    input  logic [DATA_WIDTH-1:0]   reg_wdata_i,
    input  logic [DATA_WIDTH/8-1:0] reg_wstrb_i,
    input  logic                    timer_run_i,
    output logic [DATA_WIDTH-1:0]   tmr_rdata_o,
    output logic                    timer_irq_o
);

    logic [DATA_WIDTH-1:0]  wmask;
    logic                   enable_q;
    logic                   match_q;
    logic [TIMER_WIDTH-1:0] cmp_q;
    logic [TIMER_WIDTH-1:0] count_q;
    logic                   hit;
    logic                   clear;

    for (genvar b = 0; b < DATA_WIDTH/8; b++) begin : g_mask
        assign wmask[b*8 +: 8] = {8{reg_wstrb_i[b]}};
    end

    assign hit   = timer_run_i && enable_q && (count_q == cmp_q);
    assign clear = reg_wr_i && (reg_op_i == TMR_STATUS) && reg_wstrb_i[0] && reg_wdata_i[0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q <= 1'b0;
            cmp_q    <= '0;
            count_q  <= '0;
            match_q  <= 1'b0;
        end else begin
            if (reg_wr_i && reg_op_i == TMR_CTRL && reg_wstrb_i[0]) begin
                enable_q <= reg_wdata_i[0];
            end
            if (reg_wr_i && reg_op_i == TMR_CMP) begin
                cmp_q <= TIMER_WIDTH'((DATA_WIDTH'(cmp_q) & ~wmask) | (reg_wdata_i & wmask));
            end
            if (timer_run_i && enable_q) begin
                count_q <= hit ? '0 : count_q + 1'b1; // wrap on compare.
            end
            if (hit) match_q <= 1'b1; // match beats a same-cycle clear.
            else if (clear) match_q <= 1'b0;
        end
    end

    always_comb begin
        case (reg_op_i)
            TMR_CTRL:   tmr_rdata_o = DATA_WIDTH'(enable_q);
            TMR_CMP:    tmr_rdata_o = DATA_WIDTH'(cmp_q);
            TMR_COUNT:  tmr_rdata_o = DATA_WIDTH'(count_q);
            TMR_STATUS: tmr_rdata_o = DATA_WIDTH'(match_q);
            default:    tmr_rdata_o = '0;
        endcase
    end

    assign timer_irq_o = match_q;

endmodule

//--- src/adam_synth.sv
`timescale 1ns/100ps

module adam_synth import adam_cfg_pkg::*, adam_regmap_pkg::*; #(
    parameter ADDR_WIDTH  = ADDR_WIDTH_DEF,
    parameter DATA_WIDTH  = DATA_WIDTH_DEF,
    parameter GPIO_WIDTH  = GPIO_WIDTH_DEF,
    parameter TIMER_WIDTH = TIMER_WIDTH_DEF
) (
    input  logic clk,
    input  logic arst_n_i,

    input  logic pause_req_i,
    output logic pause_ack_o,

    input  logic [ADDR_WIDTH-1:0]   s_axil_aw_addr_i,
    input  logic [2:0]              s_axil_aw_prot_i,
    input  logic                    s_axil_aw_valid_i,
    output logic                    s_axil_aw_ready_o,
    input  logic [DATA_WIDTH-1:0]   s_axil_w_data_i,
    input  logic [DATA_WIDTH/8-1:0] s_axil_w_strb_i,
    input  logic                    s_axil_w_valid_i,
    output logic                    s_axil_w_ready_o,
    output logic [1:0]              s_axil_b_resp_o,
    output logic                    s_axil_b_valid_o,
    input  logic                    s_axil_b_ready_i,
    input  logic [ADDR_WIDTH-1:0]   s_axil_ar_addr_i,
    input  logic [2:0]              s_axil_ar_prot_i,
    input  logic                    s_axil_ar_valid_i,
    output logic                    s_axil_ar_ready_o,
    output logic [DATA_WIDTH-1:0]   s_axil_r_data_o,
    output logic [1:0]              s_axil_r_resp_o,
    output logic                    s_axil_r_valid_o,
    input  logic                    s_axil_r_ready_i,

    input  logic [GPIO_WIDTH-1:0]            gpio_i,
    output logic [GPIO_WIDTH-1:0]            gpio_o,
    output logic [GPIO_WIDTH-1:0]            gpio_mode_o,
    output logic [GPIO_WIDTH-1:0]            gpio_otype_o,
    output logic [FUNC_WIDTH*GPIO_WIDTH-1:0] gpio_func_o,

    output logic timer_irq_o
);

    logic                    reg_wr;
    reg_op_e                 reg_op;
    logic [DATA_WIDTH-1:0]   reg_wdata;
    logic [DATA_WIDTH/8-1:0] reg_wstrb;
    logic                    timer_run;
    logic [DATA_WIDTH-1:0]   gpio_rdata;
    logic [DATA_WIDTH-1:0]   tmr_rdata;

    adam_bus_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) adam_bus_ctrl_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),

        .pause_req_i (pause_req_i),
        .pause_ack_o (pause_ack_o),

        .s_axil_aw_addr_i  (s_axil_aw_addr_i),
        .s_axil_aw_prot_i  (s_axil_aw_prot_i),
        .s_axil_aw_valid_i (s_axil_aw_valid_i),
        .s_axil_aw_ready_o (s_axil_aw_ready_o),
        .s_axil_w_data_i   (s_axil_w_data_i),
        .s_axil_w_strb_i   (s_axil_w_strb_i),
        .s_axil_w_valid_i  (s_axil_w_valid_i),
        .s_axil_w_ready_o  (s_axil_w_ready_o),
        .s_axil_b_resp_o   (s_axil_b_resp_o),
        .s_axil_b_valid_o  (s_axil_b_valid_o),
        .s_axil_b_ready_i  (s_axil_b_ready_i),
        .s_axil_ar_addr_i  (s_axil_ar_addr_i),
        .s_axil_ar_prot_i  (s_axil_ar_prot_i),
        .s_axil_ar_valid_i (s_axil_ar_valid_i),
        .s_axil_ar_ready_o (s_axil_ar_ready_o),
        .s_axil_r_data_o   (s_axil_r_data_o),
        .s_axil_r_resp_o   (s_axil_r_resp_o),
        .s_axil_r_valid_o  (s_axil_r_valid_o),
        .s_axil_r_ready_i  (s_axil_r_ready_i),

        .reg_wr_o     (reg_wr),
        .reg_op_o     (reg_op),
        .reg_wdata_o  (reg_wdata),
        .reg_wstrb_o  (reg_wstrb),
        .timer_run_o  (timer_run),
        .gpio_rdata_i (gpio_rdata),
        .tmr_rdata_i  (tmr_rdata)
    );

    adam_gpio #(
        .DATA_WIDTH (DATA_WIDTH),
        .GPIO_WIDTH (GPIO_WIDTH)
    ) adam_gpio_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .reg_wr_i     (reg_wr),
        .reg_op_i     (reg_op),
        .reg_wdata_i  (reg_wdata),
        .reg_wstrb_i  (reg_wstrb),
        .gpio_rdata_o (gpio_rdata),
        .gpio_i       (gpio_i),
        .gpio_o       (gpio_o),
        .gpio_mode_o  (gpio_mode_o),
        .gpio_otype_o (gpio_otype_o),
        .gpio_func_o  (gpio_func_o)
    );

    adam_timer #(
        .DATA_WIDTH  (DATA_WIDTH),
        .TIMER_WIDTH (TIMER_WIDTH)
    ) adam_timer_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .reg_wr_i    (reg_wr),
        .reg_op_i    (reg_op),
        .reg_wdata_i (reg_wdata),
        .reg_wstrb_i (reg_wstrb),
        .timer_run_i (timer_run),
        .tmr_rdata_o (tmr_rdata),
        .timer_irq_o (timer_irq_o)
    );

endmodule

//--- verification/adam_synth_tb.sv
`timescale 1ns/100ps

module adam_synth_tb import adam_cfg_pkg::*, adam_regmap_pkg::*;;

    typedef struct packed {
        logic        is_rd;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  resp;
        logic [31:0] rdata; // read only.
    } entry_t;

    logic clk;
    logic arst_n_i;
    logic pause_req_i, pause_ack_o;
    logic [31:0] aw_addr, w_data, ar_addr, r_data;
    logic [3:0]  w_strb;
    logic [2:0]  aw_prot, ar_prot;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_valid, r_ready;
    logic [1:0]  b_resp, r_resp;
    logic [15:0] gpio_i, gpio_o, gpio_mode_o, gpio_otype_o;
    logic [31:0] gpio_func_o;
    logic timer_irq_o;

    entry_t      table_q[$];
    int          errors;
    int          test_err;
    int          tests;
    logic [1:0]  resp;
    logic [31:0] rdata;
    logic [31:0] c0;
    logic [15:0] pins;

    adam_synth adam_synth_i (
        .clk (clk), .arst_n_i (arst_n_i),
        .pause_req_i (pause_req_i), .pause_ack_o (pause_ack_o),
        .s_axil_aw_addr_i (aw_addr), .s_axil_aw_prot_i (aw_prot),
        .s_axil_aw_valid_i (aw_valid), .s_axil_aw_ready_o (aw_ready),
        .s_axil_w_data_i (w_data), .s_axil_w_strb_i (w_strb),
        .s_axil_w_valid_i (w_valid), .s_axil_w_ready_o (w_ready),
        .s_axil_b_resp_o (b_resp), .s_axil_b_valid_o (b_valid), .s_axil_b_ready_i (b_ready),
        .s_axil_ar_addr_i (ar_addr), .s_axil_ar_prot_i (ar_prot),
        .s_axil_ar_valid_i (ar_valid), .s_axil_ar_ready_o (ar_ready),
        .s_axil_r_data_o (r_data), .s_axil_r_resp_o (r_resp),
        .s_axil_r_valid_o (r_valid), .s_axil_r_ready_i (r_ready),
        .gpio_i (gpio_i), .gpio_o (gpio_o), .gpio_mode_o (gpio_mode_o),
        .gpio_otype_o (gpio_otype_o), .gpio_func_o (gpio_func_o),
        .timer_irq_o (timer_irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // bytes with strobe set come from new_v and the rest stay.
    function automatic logic [31:0] apply_strobe(logic [31:0] old_v, logic [31:0] new_v,
                                                 logic [3:0] strb);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[b*8 +: 8] = strb[b] ? new_v[b*8 +: 8] : old_v[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
            test_err++;
        end
    endtask

    task automatic abort_run(string what);
        $display("timeout: no %s within 100 cycles", what);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic end_test(string name);
        tests++;
        errors += test_err;
        $display("test %0d %s: %s", tests, name, (test_err == 0) ? "ok" : "failed");
        test_err = 0;
    endtask

    task automatic start_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
        @(posedge clk);
        aw_addr  <= addr;
        w_data   <= data;
        w_strb   <= strb;
        aw_valid <= 1'b1;
        w_valid  <= 1'b1;
    endtask

    task automatic finish_write(output logic [1:0] resp_o);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            if (++n > 100) abort_run("aw_ready");
        end while (!aw_ready);
        check_val("w_ready", w_ready, 1'b1); // pulses with aw_ready.
        @(posedge clk);
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        b_ready  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            if (++n > 100) abort_run("b_valid");
        end while (!b_valid);
        resp_o = b_resp;
        @(posedge clk);
        b_ready <= 1'b0;
    endtask

    task automatic axil_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                              output logic [1:0] resp_o);
        start_write(addr, data, strb);
        finish_write(resp_o);
    endtask

    task automatic axil_read(logic [31:0] addr, output logic [1:0] resp_o,
                             output logic [31:0] data_o);
        int n;
        @(posedge clk);
        ar_addr  <= addr;
        ar_valid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            if (++n > 100) abort_run("ar_ready");
        end while (!ar_ready);
        @(posedge clk);
        ar_valid <= 1'b0;
        r_ready  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            if (++n > 100) abort_run("r_valid");
        end while (!r_valid);
        resp_o = r_resp;
        data_o = r_data;
        @(posedge clk);
        r_ready <= 1'b0;
    endtask

    task automatic add_wr(logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                          logic [1:0] exp_resp);
        table_q.push_back({1'b0, addr, data, strb, exp_resp, 32'h0});
    endtask

    task automatic add_rd(logic [31:0] addr, logic [1:0] exp_resp, logic [31:0] exp_data);
        table_q.push_back({1'b1, addr, 32'h0, 4'h0, exp_resp, exp_data});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        errors = 0;
        test_err = 0;
        tests = 0;
        void'($urandom(32'h67597750));
        arst_n_i = 1'b0;
        pause_req_i = 1'b0;
        aw_addr = '0;
        aw_prot = '0;
        aw_valid = 1'b0;
        w_data = '0;
        w_strb = '0;
        w_valid = 1'b0;
        b_ready = 1'b0;
        ar_addr = '0;
        ar_prot = '0;
        ar_valid = 1'b0;
        r_ready = 1'b0;
        gpio_i = '0;
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;

        add_wr(GPIO_OUT_OFF, 32'h0000A5C3, 4'hF, OKAY);
        add_rd(GPIO_OUT_OFF, OKAY, 32'h0000A5C3);
        add_wr(GPIO_MODE_OFF, 32'h00001234, 4'hF, OKAY);
        add_rd(GPIO_MODE_OFF, OKAY, 32'h00001234);
        add_wr(GPIO_OTYPE_OFF, 32'h000000FF, 4'hF, OKAY);
        add_rd(GPIO_OTYPE_OFF, OKAY, 32'h000000FF);
        add_wr(GPIO_FUNC_OFF, 32'hDEADBEEF, 4'hF, OKAY);
        add_rd(GPIO_FUNC_OFF, OKAY, 32'hDEADBEEF);
        add_wr(GPIO_OUT_OFF, 32'h12347700, 4'b0010, OKAY);
        add_rd(GPIO_OUT_OFF, OKAY, apply_strobe(32'hA5C3, 32'h12347700, 4'b0010) & 32'hFFFF);
        add_wr(GPIO_FUNC_OFF, 32'h11223344, 4'b0101, OKAY);
        add_rd(GPIO_FUNC_OFF, OKAY, apply_strobe(32'hDEADBEEF, 32'h11223344, 4'b0101));
        add_wr(32'h40, 32'hFFFFFFFF, 4'hF, SLVERR); // unmapped.
        add_rd(32'h40, SLVERR, 32'h0);
        add_wr(GPIO_IN_OFF, 32'hFFFF, 4'hF, SLVERR);
        add_wr(TMR_COUNT_OFF, 32'h55, 4'hF, SLVERR);
        add_rd(GPIO_OUT_OFF, OKAY, 32'h000077C3);
        add_rd(TMR_COUNT_OFF, OKAY, 32'h0);

        foreach (table_q[i]) begin
            if (table_q[i].is_rd) begin
                axil_read(table_q[i].addr, resp, rdata);
                check_val("r_resp", resp, table_q[i].resp);
                check_val("r_data", rdata, table_q[i].rdata);
            end else begin
                axil_write(table_q[i].addr, table_q[i].data, table_q[i].strb, resp);
                check_val("b_resp", resp, table_q[i].resp);
            end
        end
        end_test("register table");

        @(negedge clk);
        check_val("gpio_o", gpio_o, 16'h77C3);
        check_val("gpio_mode_o", gpio_mode_o, 16'h1234);
        check_val("gpio_otype_o", gpio_otype_o, 16'h00FF);
        check_val("gpio_func_o", gpio_func_o, apply_strobe(32'hDEADBEEF, 32'h11223344, 4'b0101));
        end_test("pin outputs");

        pins = 16'($urandom());
        @(posedge clk);
        gpio_i <= pins;
        repeat (3) @(posedge clk);
        axil_read(GPIO_IN_OFF, resp, rdata);
        check_val("gpio_in", rdata, {16'h0, pins});
        end_test("pin input");

        axil_write(TMR_CMP_OFF, 32'd20, 4'hF, resp);
        axil_write(TMR_CTRL_OFF, 32'h1, 4'hF, resp);
        for (int n = 0; !timer_irq_o; n++) begin
            if (n > 100) abort_run("timer_irq_o");
            @(negedge clk);
        end
        axil_read(TMR_STATUS_OFF, resp, rdata);
        check_val("tmr_status", rdata, 32'h1);
        axil_write(TMR_STATUS_OFF, 32'h1, 4'hF, resp);
        @(negedge clk);
        check_val("timer_irq_o", timer_irq_o, 1'b0);
        axil_write(TMR_CTRL_OFF, 32'h0, 4'hF, resp);
        axil_read(TMR_COUNT_OFF, resp, c0);
        repeat (5) @(posedge clk);
        axil_read(TMR_COUNT_OFF, resp, rdata);
        check_val("tmr_count", rdata, c0);
        end_test("timer match");

        // count runs freely and a long pause must not advance it.
        axil_write(TMR_CMP_OFF, 32'hFFFFFFFF, 4'hF, resp);
        axil_write(TMR_CTRL_OFF, 32'h1, 4'hF, resp);
        axil_read(TMR_COUNT_OFF, resp, c0);
        @(posedge clk);
        pause_req_i <= 1'b1;
        for (int n = 0; !pause_ack_o; n++) begin
            if (n > 100) abort_run("pause_ack_o");
            @(negedge clk);
        end
        start_write(GPIO_OUT_OFF, 32'h0000BEEF, 4'hF);
        repeat (60) begin
            @(negedge clk);
            assert (!aw_ready && !w_ready) else begin
                $display("the write was accepted while the bus was paused at t=%0t", $time);
                test_err++;
            end
        end
        @(posedge clk);
        pause_req_i <= 1'b0;
        finish_write(resp);
        check_val("b_resp", resp, OKAY);
        axil_read(TMR_COUNT_OFF, resp, rdata);
        assert (rdata - c0 < 32'd40) else begin
            $display("FAIL t=%0t tmr_count advanced during pause from %h to %h",
                     $time, c0, rdata);
            test_err++;
        end
        axil_write(TMR_CTRL_OFF, 32'h0, 4'hF, resp);
        end_test("pause");

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- adam_lite.f
src/adam_cfg_pkg.sv
src/adam_regmap_pkg.sv
src/adam_bus_ctrl.sv
src/adam_gpio.sv
src/adam_timer.sv
src/adam_synth.sv
verification/adam_synth_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module adam_synth_tb -f adam_lite.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vadam_synth_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
